/* logic/fetchPkg.sv */
// Fetch pipeline shared types
// and constants
`default_nettype none

package fetchPkg;

    // --------------------
    // Basic widths
    // --------------------

    // Fetch virtual address, equal to physical here
    typedef logic [31:0] vAddrT;
    // One instruction word
    typedef logic [31:0] instWordT;
    // One bit per slot of a 4-word block
    typedef logic [3:0] instEnT;
    // Exception code
    typedef logic [4:0] excCodeT;
    // Four words, one cache line
    typedef logic [127:0] lineDataT;

    // Miss handling in the control FSM
    typedef enum logic [1:0] {
        MISS_IDLE,
        MISS_WAIT,
        MISS_FILL
    } missStateT;

    // --------------------
    // Pipeline payloads
    // --------------------

    // PC generator to stage 1
    typedef struct packed {
        vAddrT   vAddr;
        instEnT  instEnable;
        logic    hasException;
        excCodeT excCode;
    } fetchReqT;

    // Stage 1 to stage 2
    typedef struct packed {
        fetchReqT req;
        logic     isCanceled;
    } stage1T;

    // Stage 2 to stage 3 and on to the decoder
    typedef struct packed {
        vAddrT    vAddr;
        lineDataT insts;
        instEnT   instEnable;
        logic     hasException;
        excCodeT  excCode;
    } fetchBlockT;

    // Refill line from outside memory
    typedef struct packed {
        vAddrT    lineAddr;
        lineDataT data;
    } refillT;

    // Fixed addresses and codes
    localparam vAddrT   RESET_PC   = 32'hBFC00000;
    localparam vAddrT   EXC_VECTOR = 32'hBFC00380;
    localparam excCodeT EXC_ADEL   = 5'd4;
    localparam excCodeT NO_EXC     = 5'd0;

endpackage

`default_nettype wire

/* logic/fetchCtrl.sv */
// Fetch control, miss FSM and allowin chain
`timescale 1ns/1ps
`default_nettype none

module fetchCtrl (
    input  logic clk,
    input  logic arstN_i,
    input  logic redirectValid_i,
    input  logic flush_i,
    input  logic s1Valid_i,
    input  logic s2Valid_i,
    input  logic s2Hit_i,
    input  logic s2HasExc_i,
    input  logic refillValid_i,
    input  logic s3Allowin_i,
    output logic issue_o,
    output logic s2Allowin_o,
    output logic cancel_o,
    output logic missReq_o
);
    import fetchPkg::*;

    missStateT state;
    missStateT stateNext;
    logic      s2Ready;
    logic      s2Miss;
    logic      s2Leave;
    logic      missPending;

    // Either event kills everything in flight
    assign cancel_o = redirectValid_i | flush_i;

    // Stage 2 can go on a hit, a forwarded fill, or an exception
    assign s2Ready     = s2Hit_i | s2HasExc_i;
    assign s2Miss      = s2Valid_i & ~s2Ready;
    assign s2Leave     = s2Valid_i & s2Ready & s3Allowin_i;
    assign missPending = (state == MISS_WAIT);

    // --------------------
    // Allowin chain
    // --------------------
    assign s2Allowin_o = ~missPending & (~s2Valid_i | (s2Ready & s3Allowin_i));
    // Stage 1 takes a new request when empty or moving on
    assign issue_o     = ~s1Valid_i | s2Allowin_o;

    // Level request, low once the refill has been seen
    assign missReq_o = s2Miss & (state != MISS_FILL);

    // --------------------
    // Miss FSM
    // --------------------
    always_comb begin
        stateNext = state;
        unique case (state)
            MISS_IDLE: begin
                // Refill may already be on the port in the same cycle
                if (s2Miss) begin
                    stateNext = refillValid_i ? MISS_FILL : MISS_WAIT;
                end
            end
            MISS_WAIT: begin
                if (refillValid_i || !s2Miss) begin
                    stateNext = MISS_FILL;
                end
            end
            MISS_FILL: begin
                if (!s2Valid_i || s2Leave) begin
                    stateNext = MISS_IDLE;
                end else if (s2Miss) begin
                    // Refill was for an abandoned line, keep asking
                    stateNext = MISS_WAIT;
                end
            end
            default: stateNext = MISS_IDLE;
        endcase
        if (cancel_o) begin
            stateNext = MISS_IDLE;
        end
    end

    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            state <= MISS_IDLE;
        end else begin
            state <= stateNext;
        end
    end

endmodule

`default_nettype wire

/* logic/pcGen.sv */
// Fetch PC generator
`timescale 1ns/1ps
`default_nettype none

module pcGen (
    input  logic              clk,
    input  logic              arstN_i,
    input  logic              issue_i,
    input  logic              cancel_i,
    input  logic              redirectValid_i,
    input  fetchPkg::vAddrT   redirectPc_i,
    output fetchPkg::fetchReqT fetchReq_o
);
    import fetchPkg::*;

    vAddrT pc;
    vAddrT seqPc;
    logic  misaligned;

    // Next block is aligned, whatever the current word offset
    assign seqPc = {pc[31:4], 4'b0000} + 32'd16;

    // Word alignment check
    assign misaligned = (pc[1:0] != 2'b00);

    // --------------------
    // Request fields
    // --------------------
    assign fetchReq_o.vAddr        = pc;
    // Slots from the word offset to the end of the block
    assign fetchReq_o.instEnable   = instEnT'(4'b1111 << pc[3:2]);
    assign fetchReq_o.hasException = misaligned;
    assign fetchReq_o.excCode      = misaligned ? EXC_ADEL : NO_EXC;

    // PC register
    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            pc <= RESET_PC;
        end else if (cancel_i) begin
            // Redirect wins over flush when both come
            pc <= redirectValid_i ? redirectPc_i : EXC_VECTOR;
        end else if (issue_i) begin
            pc <= seqPc;
        end
    end

endmodule

`default_nettype wire

/* logic/firstCacheStage.sv */
// Instruction cache stage 1 register
`timescale 1ns/1ps
`default_nettype none

module firstCacheStage (
    input  logic               clk,
    input  logic               arstN_i,
    input  logic               issue_i,
    input  logic               cancel_i,
    input  logic               s2Allowin_i,
    input  fetchPkg::fetchReqT fetchReq_i,
    output logic               s1Valid_o,
    output fetchPkg::stage1T   s1_o
);
    import fetchPkg::*;

    logic     hasData;
    logic     isCanceled;
    fetchReqT req;
    logic     moveOn;

    // Content goes to stage 2 this cycle
    assign moveOn = hasData & s2Allowin_i;

    // --------------------
    // Valid level
    // --------------------
    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            hasData <= 1'b0;
        end else if (issue_i) begin
            hasData <= 1'b1;
        end else if (moveOn) begin
            // Empties when nothing new follows
            hasData <= 1'b0;
        end
    end

    // --------------------
    // Cancel mark
    // --------------------
    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            isCanceled <= 1'b0;
        end else if (issue_i) begin
            // Cancel in the capture cycle marks the new entry
            isCanceled <= cancel_i;
        end else if (hasData && cancel_i) begin
            // Entry stuck waiting for stage 2
            isCanceled <= 1'b1;
        end
    end

    // Request payload
    always_ff @(posedge clk) begin
        if (issue_i) begin
            req <= fetchReq_i;
        end
    end

    assign s1Valid_o       = hasData;
    assign s1_o.req        = req;
    assign s1_o.isCanceled = isCanceled;

endmodule

`default_nettype wire

/* logic/secondCacheStage.sv */
// Instruction cache stage 2, tag and data lookup
`timescale 1ns/1ps
`default_nettype none

module secondCacheStage #(
    parameter int IndexWidth = 6
) (
    input  logic                 clk,
    input  logic                 arstN_i,
    input  logic                 s1Valid_i,
    input  fetchPkg::stage1T     s1_i,
    input  logic                 s2Allowin_i,
    input  logic                 s3Allowin_i,
    input  logic                 cancel_i,
    input  logic                 refillValid_i,
    input  fetchPkg::refillT     refill_i,
    output logic                 s2Valid_o,
    output logic                 s2Hit_o,
    output logic                 s2HasExc_o,
    output fetchPkg::vAddrT      missAddr_o,
    output fetchPkg::fetchBlockT s2Block_o
);
    import fetchPkg::*;

    localparam int NumLines = 1 << IndexWidth;
    // Address bits above the index and the 16-byte offset
    localparam int TagWidth = 28 - IndexWidth;

    typedef logic [IndexWidth-1:0] lineIndexT;
    typedef logic [TagWidth-1:0]   lineTagT;

    // Cache arrays, one way
    logic [NumLines-1:0] lineValid;
    lineTagT             tagArr  [NumLines];
    lineDataT            dataArr [NumLines];

    // Held request
    logic      valid;
    fetchReqT  req;
    lineIndexT index;
    lineTagT   tag;
    logic      tagHit;
    logic      hit;
    logic      ready;
    logic      leave;
    lineDataT  lineData;

    // Refill side
    lineIndexT refillIndex;
    logic      refillMatch;
    logic      fwdValid;
    lineDataT  fwdData;

    // --------------------
    // Lookup
    // --------------------
    assign index  = req.vAddr[IndexWidth+3:4];
    assign tag    = req.vAddr[31:IndexWidth+4];
    assign tagHit = lineValid[index] & (tagArr[index] == tag);

    // Forwarded line counts as a hit
    assign hit   = valid & ~req.hasException & (fwdValid | tagHit);
    assign ready = hit | (valid & req.hasException);
    // Block moves to stage 3 this cycle
    assign leave = ready & s3Allowin_i;

    // Refill addressed to the line held here
    assign refillIndex = refill_i.lineAddr[IndexWidth+3:4];
    assign refillMatch = refillValid_i & valid & ~req.hasException
                       & (refill_i.lineAddr[31:4] == req.vAddr[31:4]);

    // --------------------
    // Stage register
    // --------------------
    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            valid <= 1'b0;
        end else if (cancel_i) begin
            // Held and incoming entries both belong to the old path
            valid <= 1'b0;
        end else if (s2Allowin_i) begin
            valid <= s1Valid_i & ~s1_i.isCanceled;
        end
    end

    always_ff @(posedge clk) begin
        if (s2Allowin_i) begin
            req <= s1_i.req;
        end
    end

    // Forward register for the refilled line
    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            fwdValid <= 1'b0;
        end else if (cancel_i || leave) begin
            fwdValid <= 1'b0;
        end else if (refillMatch) begin
            fwdValid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (refillMatch) begin
            fwdData <= refill_i.data;
        end
    end

    // --------------------
    // Array write
    // --------------------
    // Every refill is written, also one for an abandoned miss
    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            lineValid <= '0;
        end else if (refillValid_i) begin
            lineValid[refillIndex] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (refillValid_i) begin
            tagArr[refillIndex]  <= refill_i.lineAddr[31:IndexWidth+4];
            dataArr[refillIndex] <= refill_i.data;
        end
    end

    // --------------------
    // Outputs
    // --------------------
    assign s2Valid_o  = valid;
    assign s2Hit_o    = hit;
    assign s2HasExc_o = valid & req.hasException;
    // Line-aligned address of the held request
    assign missAddr_o = {req.vAddr[31:4], 4'b0000};

    assign lineData = fwdValid ? fwdData : dataArr[index];

    // Exception entries carry no instructions
    assign s2Block_o.vAddr        = req.vAddr;
    assign s2Block_o.insts        = req.hasException ? '0 : lineData;
    assign s2Block_o.instEnable   = req.instEnable;
    assign s2Block_o.hasException = req.hasException;
    assign s2Block_o.excCode      = req.excCode;

endmodule

`default_nettype wire

/* logic/thirdCacheStage.sv */
// Instruction cache stage 3, output to decoder
`timescale 1ns/1ps
`default_nettype none

module thirdCacheStage (
    input  logic                 clk,
    input  logic                 arstN_i,
    input  logic                 s2Valid_i,
    input  logic                 s2Hit_i,
    input  fetchPkg::fetchBlockT s2Block_i,
    input  logic                 cancel_i,
    input  logic                 outAllowin_i,
    output logic                 s3Allowin_o,
    output logic                 outValid_o,
    output fetchPkg::fetchBlockT outBlock_o
);
    import fetchPkg::*;

    logic       hasData;
    logic       s2Ready;
    fetchBlockT block;

    // --------------------
    // Capture condition
    // --------------------
    // Hits, forwarded fills and exception entries are all ready
    assign s2Ready = s2Valid_i & (s2Hit_i | s2Block_i.hasException);

    // Free when empty or the decoder takes it now
    assign s3Allowin_o = ~hasData | outAllowin_i;

    // Valid level
    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            hasData <= 1'b0;
        end else if (cancel_i) begin
            // Old path block dropped
            hasData <= 1'b0;
        end else if (s3Allowin_o) begin
            hasData <= s2Ready;
        end
    end

    // Block register, held under back-pressure
    always_ff @(posedge clk) begin
        if (s3Allowin_o && s2Ready) begin
            block <= s2Block_i;
        end
    end

    assign outValid_o = hasData;
    assign outBlock_o = block;

endmodule

`default_nettype wire

/* logic/fetchTop.sv */
// Instruction fetch front end top level
`timescale 1ns/1ps
`default_nettype none

module fetchTop #(
    parameter int IndexWidth = 6
) (
    input  logic                 clk,
    input  logic                 arstN_i,
    input  logic                 redirectValid_i,
    input  fetchPkg::vAddrT      redirectPc_i,
    input  logic                 flush_i,
    input  logic                 refillValid_i,
    input  fetchPkg::refillT     refill_i,
    input  logic                 outAllowin_i,
    output logic                 missReq_o,
    output fetchPkg::vAddrT      missAddr_o,
    output logic                 outValid_o,
    output fetchPkg::fetchBlockT outBlock_o
);
    import fetchPkg::*;

    // --------------------
    // Internal wires
    // --------------------
    fetchReqT   fetchReq;
    logic       issue;
    logic       cancel;
    logic       s1Valid;
    stage1T     s1;
    logic       s2Allowin;
    logic       s2Valid;
    logic       s2Hit;
    logic       s2HasExc;
    fetchBlockT s2Block;
    logic       s3Allowin;

    // Control
    fetchCtrl fetchCtrl_inst (
        .clk            (clk),
        .arstN_i        (arstN_i),
        .redirectValid_i(redirectValid_i),
        .flush_i        (flush_i),
        .s1Valid_i      (s1Valid),
        .s2Valid_i      (s2Valid),
        .s2Hit_i        (s2Hit),
        .s2HasExc_i     (s2HasExc),
        .refillValid_i  (refillValid_i),
        .s3Allowin_i    (s3Allowin),
        .issue_o        (issue),
        .s2Allowin_o    (s2Allowin),
        .cancel_o       (cancel),
        .missReq_o      (missReq_o)
    );

    pcGen pcGen_inst (
        .clk            (clk),
        .arstN_i        (arstN_i),
        .issue_i        (issue),
        .cancel_i       (cancel),
        .redirectValid_i(redirectValid_i),
        .redirectPc_i   (redirectPc_i),
        .fetchReq_o     (fetchReq)
    );

    firstCacheStage firstCacheStage_inst (
        .clk        (clk),
        .arstN_i    (arstN_i),
        .issue_i    (issue),
        .cancel_i   (cancel),
        .s2Allowin_i(s2Allowin),
        .fetchReq_i (fetchReq),
        .s1Valid_o  (s1Valid),
        .s1_o       (s1)
    );

    // Cache arrays live here
    secondCacheStage #(
        .IndexWidth(IndexWidth)
    ) secondCacheStage_inst (
        .clk          (clk),
        .arstN_i      (arstN_i),
        .s1Valid_i    (s1Valid),
        .s1_i         (s1),
        .s2Allowin_i  (s2Allowin),
        .s3Allowin_i  (s3Allowin),
        .cancel_i     (cancel),
        .refillValid_i(refillValid_i),
        .refill_i     (refill_i),
        .s2Valid_o    (s2Valid),
        .s2Hit_o      (s2Hit),
        .s2HasExc_o   (s2HasExc),
        .missAddr_o   (missAddr_o),
        .s2Block_o    (s2Block)
    );

    thirdCacheStage thirdCacheStage_inst (
        .clk         (clk),
        .arstN_i     (arstN_i),
        .s2Valid_i   (s2Valid),
        .s2Hit_i     (s2Hit),
        .s2Block_i   (s2Block),
        .cancel_i    (cancel),
        .outAllowin_i(outAllowin_i),
        .s3Allowin_o (s3Allowin),
        .outValid_o  (outValid_o),
        .outBlock_o  (outBlock_o)
    );

endmodule

`default_nettype wire

/* dv/fetchTop_checker.sv */
// Fetch top level port assertions
`timescale 1ns/1ps
`default_nettype none

module fetchTop_checker (
    input logic                 clk,
    input logic                 arstN_i,
    input logic                 outAllowin_i,
    input logic                 missReq_o,
    input fetchPkg::vAddrT      missAddr_o,
    input logic                 outValid_o,
    input fetchPkg::fetchBlockT outBlock_o
);
    // Nothing leaves the front end during reset
    resetQuiet: assert property (@(posedge clk) !arstN_i |-> (!outValid_o && !missReq_o))
        else $error("outValid_o or missReq_o high during reset");

    // Miss address held for the whole request
    missAddrHeld: assert property (@(posedge clk) disable iff (!arstN_i)
        missReq_o |=> (!missReq_o || $stable(missAddr_o)))
        else $error("missAddr_o changed while missReq_o was high");

    // Block held under decoder back-pressure
    blockHeld: assert property (@(posedge clk) disable iff (!arstN_i)
        (outValid_o && !outAllowin_i) |=> (!outValid_o || $stable(outBlock_o)))
        else $error("outBlock_o changed while stalled");

endmodule

bind fetchTop fetchTop_checker fetchTop_checker_inst (.*);

`default_nettype wire

/* dv/fetchTb.sv */
// Fetch front end testbench
`timescale 1ns/1ps
`default_nettype none

module fetchTb;
    import fetchPkg::*;

    localparam logic [1:0] STEP_RUN      = 2'd0;
    localparam logic [1:0] STEP_REDIRECT = 2'd1;
    localparam logic [1:0] STEP_FLUSH    = 2'd2;
    localparam int         NumSteps      = 8;

    // One stimulus step, kind, target, blocks to collect, back-pressure
    typedef struct packed {
        logic [1:0] kind;
        vAddrT      target;
        logic [7:0] blocks;
        logic       backPressure;
    } stepT;

    logic       clk;
    logic       arstN_i;
    logic       redirectValid_i;
    vAddrT      redirectPc_i;
    logic       flush_i;
    logic       refillValid_i;
    refillT     refill_i;
    logic       outAllowin_i;
    logic       missReq_o;
    vAddrT      missAddr_o;
    logic       outValid_o;
    fetchBlockT outBlock_o;

    stepT  steps [NumSteps];
    vAddrT expPc;
    vAddrT noMissLine;
    int    cycleCount;
    int    cycleLimit;
    int    errorCount;
    bit    filled [vAddrT];

    fetchTop #(.IndexWidth(6)) fetchTop_inst (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic vAddrT lineOf(input vAddrT addr);
        return {addr[31:4], 4'b0000};
    endfunction

    // Memory content, every word is its byte address plus 0x1000
    function automatic lineDataT memLine(input vAddrT lineAddr);
        lineDataT data;
        for (int i = 0; i < 4; i++) begin
            data[32*i +: 32] = lineAddr + 32'(4 * i) + 32'h1000;
        end
        return data;
    endfunction

    task automatic failRun(input string why);
        errorCount++;
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "Run stopped at first error");
    endtask

    task automatic checkValue(input string name, input logic [127:0] actual,
                              input logic [127:0] expected);
        if (actual !== expected) begin
            failRun($sformatf("[FAIL] t=%0t %s actual=%0h expected=%0h",
                              $time, name, actual, expected));
        end
    endtask

    // --------------------
    // Reference model
    // --------------------
    task automatic checkBlock(input fetchBlockT blk);
        logic   misaligned;
        instEnT expEn;
        misaligned = (expPc[1:0] != 2'b00);
        // Slot wanted when at or past the word offset
        for (int i = 0; i < 4; i++) begin
            expEn[i] = (i >= int'(expPc[3:2]));
        end
        checkValue("outBlock_o.vAddr", 128'(blk.vAddr), 128'(expPc));
        checkValue("outBlock_o.hasException", 128'(blk.hasException), 128'(misaligned));
        if (misaligned) begin
            checkValue("outBlock_o.excCode", 128'(blk.excCode), 128'(EXC_ADEL));
            checkValue("outBlock_o.insts", blk.insts, 128'(0));
        end else begin
            checkValue("outBlock_o.excCode", 128'(blk.excCode), 128'(NO_EXC));
            checkValue("outBlock_o.instEnable", 128'(blk.instEnable), 128'(expEn));
            checkValue("outBlock_o.insts", blk.insts, memLine(lineOf(expPc)));
        end
        // Next block is aligned
        expPc = lineOf(expPc) + 32'd16;
    endtask

    // Stage 2 holds the expected block or the one after it
    task automatic checkMissAddr(input vAddrT addr);
        vAddrT expAddr;
        expAddr = lineOf(expPc);
        if (addr == expAddr + 32'd16) begin
            expAddr = addr;
        end
        checkValue("missAddr_o", 128'(addr), 128'(expAddr));
        if (addr == noMissLine) begin
            failRun("Miss requested for a misaligned fetch that should raise an exception");
        end
        if (filled.exists(addr)) begin
            failRun("Miss requested again for a line that was already refilled");
        end
    endtask

    // --------------------
    // Memory model
    // --------------------
    initial begin
        vAddrT reqAddr;
        int    delay;
        wait (arstN_i === 1'b1);
        forever begin
            @(negedge clk);
            if (missReq_o) begin
                reqAddr = missAddr_o;
                // Old path miss in the cancel cycle is still served
                if (!redirectValid_i && !flush_i) begin
                    checkMissAddr(reqAddr);
                end
                delay = 1 + int'($urandom % 8);
                repeat (delay) @(posedge clk);
                #1;
                refillValid_i     = 1'b1;
                refill_i.lineAddr = reqAddr;
                refill_i.data     = memLine(reqAddr);
                @(posedge clk);
                #1;
                refillValid_i = 1'b0;
                filled[reqAddr] = 1'b1;
            end
        end
    end

    // Timeout watchdog
    initial begin
        cycleCount = 0;
        forever begin
            @(posedge clk);
            cycleCount++;
            if (cycleCount > cycleLimit) begin
                failRun("Timeout, the expected blocks did not all arrive");
            end
        end
    end

    // --------------------
    // Stimulus loop
    // --------------------
    initial begin
        int   taken;
        stepT st;
        void'($urandom(32'h8633d76e));
        steps[0] = '{STEP_RUN, RESET_PC, 8'd6, 1'b0};
        steps[1] = '{STEP_RUN, RESET_PC, 8'd4, 1'b1};
        steps[2] = '{STEP_REDIRECT, 32'hBFC00100, 8'd3, 1'b0};
        steps[3] = '{STEP_REDIRECT, 32'hBFC00206, 8'd3, 1'b0};
        steps[4] = '{STEP_REDIRECT, 32'hBFC00248, 8'd2, 1'b0};
        steps[5] = '{STEP_FLUSH, 32'h0, 8'd4, 1'b1};
        steps[6] = '{STEP_REDIRECT, RESET_PC, 8'd6, 1'b1};
        steps[7] = '{STEP_RUN, RESET_PC, 8'd4, 1'b1};
        cycleLimit = 0;
        for (int s = 0; s < NumSteps; s++) begin
            cycleLimit += 40 * int'(steps[s].blocks);
        end
        errorCount      = 0;
        expPc           = RESET_PC;
        noMissLine      = 32'hFFFF_FFF0;
        arstN_i         = 1'b0;
        redirectValid_i = 1'b0;
        redirectPc_i    = '0;
        flush_i         = 1'b0;
        refillValid_i   = 1'b0;
        refill_i        = '0;
        outAllowin_i    = 1'b0;
        repeat (4) @(posedge clk);
        #1 arstN_i = 1'b1;
        for (int s = 0; s < NumSteps; s++) begin
            st = steps[s];
            if (st.kind != STEP_RUN) begin
                // Cancel cycle, the decoder takes nothing
                @(posedge clk);
                #1;
                outAllowin_i    = 1'b0;
                redirectValid_i = (st.kind == STEP_REDIRECT);
                flush_i         = (st.kind == STEP_FLUSH);
                redirectPc_i    = st.target;
                expPc           = (st.kind == STEP_FLUSH) ? EXC_VECTOR : st.target;
                noMissLine      = (expPc[1:0] != 2'b00) ? lineOf(expPc) : 32'hFFFF_FFF0;
            end
            taken = 0;
            while (taken < int'(st.blocks)) begin
                @(posedge clk);
                #1;
                redirectValid_i = 1'b0;
                flush_i         = 1'b0;
                outAllowin_i    = st.backPressure ? (($urandom & 32'd1) != 32'd0) : 1'b1;
                @(negedge clk);
                if (outValid_o && outAllowin_i) begin
                    checkBlock(outBlock_o);
                    taken++;
                end
            end
        end
        @(posedge clk);
        #1 outAllowin_i = 1'b0;
        repeat (4) @(posedge clk);
        if (errorCount == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
logic/fetchPkg.sv
logic/fetchCtrl.sv
logic/pcGen.sv
logic/firstCacheStage.sv
logic/secondCacheStage.sv
logic/thirdCacheStage.sv
logic/fetchTop.sv
dv/fetchTop_checker.sv
dv/fetchTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the fetch testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --top-module fetchTb -f files.f -o fetchSim \
    > build.log 2>&1 && ./obj_dir/fetchSim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "Build or simulation failed"; exit 1; }
grep -q "=== FAIL ===" sim.log && { cat sim.log; echo "Simulation failed"; exit 1; } \
    || { echo "Simulation passed"; exit 0; }
